/* design/cpu_defines.svh */
// Configuration macros for the pipelined MIPS subset CPU
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction width
`define CPU_XLEN 32

// Architectural registers, 5-bit index
`define CPU_NREGS 32

// Data memory depth in words
// Address wraps modulo the depth
`define CPU_DMEM_WORDS 64

// Program depth in words
`define CPU_IMEM_WORDS 64

`endif

/* design/cpu_pkg.sv */
// Shared encodings and stage-boundary types for the pipelined CPU
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] wordT;
	typedef logic [$clog2(`CPU_NREGS)-1:0] regIdxT;

	// Primary opcode field
	typedef enum logic [5:0] {
		rType = 6'h00,
		beq   = 6'h04,
		bne   = 6'h05,
		bgtz  = 6'h07,
		addi  = 6'h08,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcodeE;

	// R-type function field
	typedef enum logic [5:0] {
		sll  = 6'h00,
		add  = 6'h20,
		addu = 6'h21,
		sub  = 6'h22,
		subu = 6'h23,
		andF = 6'h24,
		orF  = 6'h25,
		slt  = 6'h2a,
		sltu = 6'h2b
	} funcE;

	// ALU control encoding
	typedef enum logic [2:0] {
		andOp  = 3'd0,
		orOp   = 3'd1,
		addOp  = 3'd2,
		sltOp  = 3'd3,
		adduOp = 3'd4,
		sllOp  = 3'd5,
		subOp  = 3'd6,
		sltuOp = 3'd7
	} aluOpE;

	typedef enum logic [1:0] {
		noBranch = 2'd0,
		brEq     = 2'd1,
		brNe     = 2'd2,
		brGtz    = 2'd3
	} branchE;

	typedef struct packed {
		logic valid;
		aluOpE aluOp;
		branchE branch;
		logic aluSrcImm;
		logic regDstRd;
		logic memWr;
		logic memToReg;
		logic regWr;
		regIdxT rt;
		regIdxT rd;
		logic [$clog2(`CPU_XLEN)-1:0] shamt;
		wordT busA;
		wordT busB;
		wordT imm32;
		wordT pc;
	} idExS;

	typedef struct packed {
		logic valid;
		logic memWr;
		logic memToReg;
		logic regWr;
		regIdxT rw;
		wordT aluOut;
		wordT storeData;
	} exMemS;

	typedef struct packed {
		logic en;
		regIdxT rw;
		wordT data;
	} regWrS;

	typedef struct packed {
		logic valid;
		regIdxT rw;
		wordT data;
	} retireS;

	// Store address is the data-memory word index
	typedef struct packed {
		logic valid;
		wordT addr;
		wordT data;
	} storeS;

endpackage

/* design/fetch.sv */
// Fetch stage: program counter and the IF/ID register
`include "cpu_defines.svh"

module fetch (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic redirectEn,
	input logic [`CPU_XLEN-1:0] redirectPc,
	output logic [`CPU_XLEN-1:0] imemAddr,
	input logic [`CPU_XLEN-1:0] imemData,
	output logic ifValid,
	output logic [`CPU_XLEN-1:0] ifInst,
	output logic [`CPU_XLEN-1:0] ifPc
);

	logic [`CPU_XLEN-1:0] pc;

	assign imemAddr = pc;

	// Redirect wins over a stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ifValid <= 1'b0;
		end else if (redirectEn) begin
			pc <= redirectPc;
			ifValid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + `CPU_XLEN'(4);
			ifValid <= 1'b1;
		end
	end

	// Instruction word and its address
	always_ff @(posedge clk) begin
		if (!stall && !redirectEn) begin
			ifInst <= imemData;
			ifPc <= pc;
		end
	end

endmodule

/* design/decode.sv */
// Decode stage: control decode, register file, interlock and ID/EX register
`include "cpu_defines.svh"

module decode (
	input logic clk,
	input logic rstN,
	input logic ifValid,
	input logic [`CPU_XLEN-1:0] ifInst,
	input logic [`CPU_XLEN-1:0] ifPc,
	input logic redirectEn,
	input cpu_pkg::regWrS wb,
	input cpu_pkg::idExS exPending,
	input cpu_pkg::exMemS memPending,
	output logic stall,
	output cpu_pkg::idExS idEx
);

	cpu_pkg::opcodeE opcode;
	cpu_pkg::funcE funct;
	cpu_pkg::regIdxT rs;
	cpu_pkg::regIdxT rt;
	cpu_pkg::regIdxT exRw;
	cpu_pkg::wordT regs [`CPU_NREGS];
	cpu_pkg::wordT busA;
	cpu_pkg::wordT busB;
	cpu_pkg::idExS idNext;
	logic useRs;
	logic useRt;
	logic exHit;
	logic memHit;

	assign opcode = cpu_pkg::opcodeE'(ifInst[31:26]);
	assign funct = cpu_pkg::funcE'(ifInst[5:0]);
	assign rs = ifInst[25:21];
	assign rt = ifInst[20:16];

	// Register file, written from the writeback bus
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.rw] <= wb.data;
		end
	end

	// Same-cycle writeback bypasses the array
	always_comb begin
		if (rs == '0)
			busA = '0;
		else if (wb.en && wb.rw == rs)
			busA = wb.data;
		else
			busA = regs[rs];
		if (rt == '0)
			busB = '0;
		else if (wb.en && wb.rw == rt)
			busB = wb.data;
		else
			busB = regs[rt];
	end

	always_comb begin
		idNext = '0;
		idNext.valid = ifValid;
		idNext.aluOp = cpu_pkg::addOp;
		idNext.branch = cpu_pkg::noBranch;
		idNext.rt = rt;
		idNext.rd = ifInst[15:11];
		idNext.shamt = ifInst[10:6];
		idNext.busA = busA;
		idNext.busB = busB;
		idNext.imm32 = {{(`CPU_XLEN-16){ifInst[15]}}, ifInst[15:0]};
		idNext.pc = ifPc;
		useRs = 1'b1;
		useRt = 1'b0;
		case (opcode)
			cpu_pkg::rType: begin
				idNext.regDstRd = 1'b1;
				idNext.regWr = 1'b1;
				useRt = 1'b1;
				// sll reads only rt
				useRs = (funct != cpu_pkg::sll);
				case (funct)
					cpu_pkg::add: idNext.aluOp = cpu_pkg::addOp;
					cpu_pkg::addu: idNext.aluOp = cpu_pkg::adduOp;
					cpu_pkg::sub: idNext.aluOp = cpu_pkg::subOp;
					cpu_pkg::subu: idNext.aluOp = cpu_pkg::subOp;
					cpu_pkg::andF: idNext.aluOp = cpu_pkg::andOp;
					cpu_pkg::orF: idNext.aluOp = cpu_pkg::orOp;
					cpu_pkg::sll: idNext.aluOp = cpu_pkg::sllOp;
					cpu_pkg::slt: idNext.aluOp = cpu_pkg::sltOp;
					cpu_pkg::sltu: idNext.aluOp = cpu_pkg::sltuOp;
					default: idNext.regWr = 1'b0;
				endcase
			end
			cpu_pkg::addi: begin
				idNext.aluSrcImm = 1'b1;
				idNext.regWr = 1'b1;
			end
			cpu_pkg::lw: begin
				idNext.aluSrcImm = 1'b1;
				idNext.memToReg = 1'b1;
				idNext.regWr = 1'b1;
			end
			cpu_pkg::sw: begin
				idNext.aluSrcImm = 1'b1;
				idNext.memWr = 1'b1;
				useRt = 1'b1;
			end
			cpu_pkg::beq: begin
				idNext.aluOp = cpu_pkg::subOp;
				idNext.branch = cpu_pkg::brEq;
				useRt = 1'b1;
			end
			cpu_pkg::bne: begin
				idNext.aluOp = cpu_pkg::subOp;
				idNext.branch = cpu_pkg::brNe;
				useRt = 1'b1;
			end
			cpu_pkg::bgtz: begin
				idNext.aluOp = cpu_pkg::subOp;
				idNext.branch = cpu_pkg::brGtz;
			end
			default: ;
		endcase
	end

	// Interlock against writers still in execute or memory
	assign exRw = exPending.regDstRd ? exPending.rd : exPending.rt;
	assign exHit = exPending.valid && exPending.regWr && exRw != '0 &&
		((useRs && exRw == rs) || (useRt && exRw == rt));
	assign memHit = memPending.valid && memPending.regWr && memPending.rw != '0 &&
		((useRs && memPending.rw == rs) || (useRt && memPending.rw == rt));
	assign stall = ifValid && (exHit || memHit);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			idEx <= '0;
		else if (redirectEn || stall)
			idEx <= '0;
		else
			idEx <= idNext;
	end

endmodule

/* design/execute.sv */
// Execute stage: ALU, branch resolution and the EX/MEM register
`include "cpu_defines.svh"

module execute (
	input logic clk,
	input logic rstN,
	input cpu_pkg::idExS idEx,
	output cpu_pkg::exMemS exMem,
	output logic redirectEn,
	output logic [`CPU_XLEN-1:0] redirectPc
);

	cpu_pkg::wordT aluB;
	cpu_pkg::wordT aluOut;
	cpu_pkg::regIdxT rw;
	logic taken;

	assign aluB = idEx.aluSrcImm ? idEx.imm32 : idEx.busB;

	always_comb begin
		aluOut = '0;
		case (idEx.aluOp)
			cpu_pkg::andOp: aluOut = idEx.busA & aluB;
			cpu_pkg::orOp: aluOut = idEx.busA | aluB;
			cpu_pkg::addOp: aluOut = idEx.busA + aluB;
			cpu_pkg::adduOp: aluOut = idEx.busA + aluB;
			cpu_pkg::subOp: aluOut = idEx.busA - aluB;
			// Shift amount comes from the instruction, operand is rt
			cpu_pkg::sllOp: aluOut = aluB << idEx.shamt;
			cpu_pkg::sltOp: aluOut = `CPU_XLEN'($signed(idEx.busA) < $signed(aluB));
			cpu_pkg::sltuOp: aluOut = `CPU_XLEN'(idEx.busA < aluB);
			default: aluOut = '0;
		endcase
	end

	// beq and bne look at the subtract result
	always_comb begin
		case (idEx.branch)
			cpu_pkg::brEq: taken = (aluOut == '0);
			cpu_pkg::brNe: taken = (aluOut != '0);
			cpu_pkg::brGtz: taken = !idEx.busA[`CPU_XLEN-1] && (idEx.busA != '0);
			default: taken = 1'b0;
		endcase
	end

	assign redirectEn = idEx.valid && taken;
	assign redirectPc = idEx.pc + `CPU_XLEN'(4) + (idEx.imm32 << 2);

	assign rw = idEx.regDstRd ? idEx.rd : idEx.rt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.memWr <= idEx.memWr;
			exMem.memToReg <= idEx.memToReg;
			exMem.regWr <= idEx.regWr;
			exMem.rw <= rw;
			exMem.aluOut <= aluOut;
			exMem.storeData <= idEx.busB;
		end
	end

endmodule

/* design/result.sv */
// Memory and writeback stages: data memory, MEM/WB register and retire report
`include "cpu_defines.svh"

module result (
	input logic clk,
	input logic rstN,
	input cpu_pkg::exMemS exMem,
	output cpu_pkg::regWrS wb,
	output cpu_pkg::retireS retire,
	output cpu_pkg::storeS store
);

	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

	cpu_pkg::wordT dmem [`CPU_DMEM_WORDS];
	logic [DMEM_AW-1:0] dmemIdx;
	cpu_pkg::wordT loadData;
	logic wbValid;
	logic wbRegWr;
	logic wbMemToReg;
	cpu_pkg::regIdxT wbRw;
	cpu_pkg::wordT wbAlu;
	cpu_pkg::wordT wbLoad;
	logic wbEn;
	cpu_pkg::wordT wbData;

	// Word index, wraps at the memory depth
	assign dmemIdx = exMem.aluOut[DMEM_AW+1:2];
	assign loadData = dmem[dmemIdx];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.valid && exMem.memWr) begin
			dmem[dmemIdx] <= exMem.storeData;
		end
	end

	assign store = '{
		valid: exMem.valid && exMem.memWr,
		addr: cpu_pkg::wordT'(dmemIdx),
		data: exMem.storeData
	};

	// MEM/WB control
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			wbRegWr <= 1'b0;
			wbMemToReg <= 1'b0;
		end else begin
			wbValid <= exMem.valid;
			wbRegWr <= exMem.regWr;
			wbMemToReg <= exMem.memToReg;
		end
	end

	// MEM/WB payload
	always_ff @(posedge clk) begin
		wbRw <= exMem.rw;
		wbAlu <= exMem.aluOut;
		wbLoad <= loadData;
	end

	// Register 0 writes are dropped here
	assign wbEn = wbValid && wbRegWr && (wbRw != '0);
	assign wbData = wbMemToReg ? wbLoad : wbAlu;

	assign wb = '{en: wbEn, rw: wbRw, data: wbData};
	assign retire = '{valid: wbEn, rw: wbRw, data: wbData};

endmodule

/* design/cpu.sv */
// Five-stage pipelined CPU for a MIPS subset
`include "cpu_defines.svh"

module cpu (
	input logic clk,
	input logic rstN,
	output logic [`CPU_XLEN-1:0] imemAddr,
	input logic [`CPU_XLEN-1:0] imemData,
	output cpu_pkg::retireS retire,
	output cpu_pkg::storeS store
);

	logic stall;
	logic redirectEn;
	logic [`CPU_XLEN-1:0] redirectPc;
	logic ifValid;
	logic [`CPU_XLEN-1:0] ifInst;
	logic [`CPU_XLEN-1:0] ifPc;
	cpu_pkg::idExS idEx;
	cpu_pkg::exMemS exMem;
	cpu_pkg::regWrS wb;

	fetch fetchStage (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redirectEn(redirectEn),
		.redirectPc(redirectPc),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifValid(ifValid),
		.ifInst(ifInst),
		.ifPc(ifPc)
	);

	// Pending writers come straight from the ID/EX and EX/MEM registers
	decode decodeStage (
		.clk(clk),
		.rstN(rstN),
		.ifValid(ifValid),
		.ifInst(ifInst),
		.ifPc(ifPc),
		.redirectEn(redirectEn),
		.wb(wb),
		.exPending(idEx),
		.memPending(exMem),
		.stall(stall),
		.idEx(idEx)
	);

	execute executeStage (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.exMem(exMem),
		.redirectEn(redirectEn),
		.redirectPc(redirectPc)
	);

	result resultStage (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.wb(wb),
		.retire(retire),
		.store(store)
	);

endmodule

/* tb/cpu_asserts.sv */
// Concurrent checks on reset, branch flush and register zero for the CPU
module cpuAsserts (
	input logic clk,
	input logic rstN,
	input logic retireValid,
	input cpu_pkg::regIdxT retireRw,
	input logic storeValid,
	input logic redirectEn,
	input logic idExValid
);

	// Nothing reports while reset is held
	resetQuiet: assert property (
		@(posedge clk) !rstN |-> (!retireValid && !storeValid)
	) else $error("retire or store valid while reset is asserted");

	// Register 0 writes are dropped before retire
	noRetireZero: assert property (
		@(posedge clk) disable iff (!rstN) retireValid |-> (retireRw != '0)
	) else $error("retire reported for register 0");

	// Taken branch leaves a bubble in ID/EX
	flushBubble: assert property (
		@(posedge clk) disable iff (!rstN) redirectEn |=> !idExValid
	) else $error("ID/EX still valid one cycle after a redirect");

endmodule

/* tb/cpu_tb.sv */
// Testbench for the pipelined CPU, runs the vector program and checks retires and stores
`include "cpu_defines.svh"

module cpu_tb;

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY = 1;
	localparam int DRAIN_CYCLES = 10;
	localparam int ROM_AW = $clog2(`CPU_IMEM_WORDS);
	localparam string VECTOR_FILE = "tb/cpu_vectors.txt";

	logic clk;
	logic rstN;
	logic [`CPU_XLEN-1:0] imemAddr;
	logic [`CPU_XLEN-1:0] imemData;
	cpu_pkg::retireS retire;
	cpu_pkg::storeS store;

	logic [`CPU_XLEN-1:0] rom [`CPU_IMEM_WORDS];
	int progLen;
	logic vectorsLoaded;
	int errors;
	int retireSeen;
	int storeSeen;

	// Expected events in program order
	logic [`CPU_XLEN-1:0] retRwQ [$];
	logic [`CPU_XLEN-1:0] retDataQ [$];
	logic [`CPU_XLEN-1:0] storeAddrQ [$];
	logic [`CPU_XLEN-1:0] storeDataQ [$];

	cpu uut (
		.clk(clk),
		.rstN(rstN),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.retire(retire),
		.store(store)
	);

	bind cpu cpuAsserts cpuChecks (
		.clk(clk),
		.rstN(rstN),
		.retireValid(retire.valid),
		.retireRw(retire.rw),
		.storeValid(store.valid),
		.redirectEn(redirectEn),
		.idExValid(idEx.valid)
	);

	always #HALF_PERIOD clk = ~clk;

	// Past the program the ROM returns sll r0, r0, 0
	always_comb begin
		if (imemAddr[`CPU_XLEN-1:ROM_AW+2] == '0)
			imemData = rom[imemAddr[ROM_AW+1:2]];
		else
			imemData = '0;
	end

	task automatic checkValue(input string name, input logic [`CPU_XLEN-1:0] got,
		input logic [`CPU_XLEN-1:0] expected);
		if (got !== expected) begin
			errors++;
			$display("ERROR: %s is %h, expected %h at time %0t", name, got, expected, $time);
		end
	endtask

	task automatic loadVectors();
		int fd;
		int code;
		string line;
		logic [7:0] kind;
		logic [`CPU_XLEN-1:0] a;
		logic [`CPU_XLEN-1:0] b;
		for (int i = 0; i < `CPU_IMEM_WORDS; i++) begin
			rom[i] = '0;
		end
		progLen = 0;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the vector file %s", VECTOR_FILE);
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code != 0 && line.len() != 0) begin
				kind = line[0];
				case (kind)
					"P": begin
						code = $sscanf(line, "P %h", a);
						if (code != 1 || progLen >= `CPU_IMEM_WORDS) begin
							errors++;
							$display("Bad or excess program line in vectors: %s", line);
						end else begin
							rom[progLen] = a;
							progLen++;
						end
					end
					"R", "S": begin
						if (kind == "R")
							code = $sscanf(line, "R %h %h", a, b);
						else
							code = $sscanf(line, "S %h %h", a, b);
						if (code != 2) begin
							errors++;
							$display("Malformed event line in vectors: %s", line);
						end else if (kind == "R") begin
							retRwQ.push_back(a);
							retDataQ.push_back(b);
						end else begin
							storeAddrQ.push_back(a);
							storeDataQ.push_back(b);
						end
					end
					// Comments and blank lines
					default: ;
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic finishRun();
		$display("Checked %0d retires and %0d stores, %0d errors", retireSeen, storeSeen, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	// Compare each reported event against the next expected one
	always @(posedge clk) begin
		if (rstN && retire.valid) begin
			retireSeen++;
			if (retRwQ.size() == 0) begin
				errors++;
				$display("Unexpected retire of register %0d when none was left", retire.rw);
			end else begin
				checkValue("retire.rw", `CPU_XLEN'(retire.rw), retRwQ.pop_front());
				checkValue("retire.data", retire.data, retDataQ.pop_front());
			end
		end
		if (rstN && store.valid) begin
			storeSeen++;
			if (storeAddrQ.size() == 0) begin
				errors++;
				$display("Unexpected store to word %0d when none was left", store.addr);
			end else begin
				checkValue("store.addr", store.addr, storeAddrQ.pop_front());
				checkValue("store.data", store.data, storeDataQ.pop_front());
			end
		end
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		errors = 0;
		retireSeen = 0;
		storeSeen = 0;
		vectorsLoaded = 1'b0;
		loadVectors();
		vectorsLoaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY rstN = 1'b1;
		while (retRwQ.size() != 0 || storeAddrQ.size() != 0) begin
			@(posedge clk);
		end
		// A few more cycles to catch stray events
		repeat (DRAIN_CYCLES) @(posedge clk);
		finishRun();
	end

	// Watchdog sized from the program length
	initial begin
		int limit;
		wait (vectorsLoaded === 1'b1);
		limit = progLen * 6 + 50;
		wait (rstN === 1'b1);
		repeat (limit) @(posedge clk);
		errors++;
		$display("Timeout after %0d cycles with %0d retires and %0d stores still missing",
			limit, retRwQ.size(), storeAddrQ.size());
		foreach (retRwQ[i]) begin
			$display("Missing retire of register %0d with data %h", retRwQ[i], retDataQ[i]);
		end
		foreach (storeAddrQ[i]) begin
			$display("Missing store to word %0d with data %h", storeAddrQ[i], storeDataQ[i]);
		end
		finishRun();
	end

endmodule

/* sources.f */
+incdir+design
design/cpu_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/result.sv
design/cpu.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

/* Makefile */
# Verilator build and run for the pipelined CPU testbench

VERILATOR ?= verilator
TOP ?= cpu_tb
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

PASS_TEXT := Simulation PASSED
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/cpu_vectors.txt */
# P <instruction hex> fills the ROM from address 0
# R <register hex> <data hex> expected retire, S <word address hex> <data hex> expected store
P 20010005  # 0  addi r1, r0, 5
P 2002FFFD  # 1  addi r2, r0, -3
P 00221820  # 2  add  r3, r1, r2
P 00222021  # 3  addu r4, r1, r2
P 00222822  # 4  sub  r5, r1, r2
P 00413023  # 5  subu r6, r2, r1
P 00223824  # 6  and  r7, r1, r2
P 00224025  # 7  or   r8, r1, r2
P 0041482A  # 8  slt  r9, r2, r1
P 0041502B  # 9  sltu r10, r2, r1
P 00015900  # 10 sll  r11, r1, 4
P 20200007  # 11 addi r0, r1, 7 dropped
P 00016020  # 12 add  r12, r0, r1
P AC080008  # 13 sw   r8, 8(r0)
P 8C0D0008  # 14 lw   r13, 8(r0)
P 21AE0001  # 15 addi r14, r13, 1 load use
P 01CE7820  # 16 add  r15, r14, r14
P AC2F000B  # 17 sw   r15, 11(r1)
P 102C0001  # 18 beq  r1, r12, +1 taken
P 20100063  # 19 addi r16, r0, 99 flushed
P 142C0001  # 20 bne  r1, r12, +1 not taken
P 20110011  # 21 addi r17, r0, 0x11
P 14220002  # 22 bne  r1, r2, +2 taken
P 20120001  # 23 addi r18, r0, 1 flushed
P 20120002  # 24 addi r18, r0, 2 flushed
P 1C400001  # 25 bgtz r2, +1 not taken
P 20130013  # 26 addi r19, r0, 0x13
P 1C200001  # 27 bgtz r1, +1 taken
P 20140077  # 28 addi r20, r0, 0x77 flushed
P 10220001  # 29 beq  r1, r2, +1 not taken
P 0271A820  # 30 add  r21, r19, r17
P 1C000001  # 31 bgtz r0, +1 not taken
P AC150000  # 32 sw   r21, 0(r0)
P 2016FFFF  # 33 addi r22, r0, -1
R 01 00000005
R 02 FFFFFFFD
R 03 00000002
R 04 00000002
R 05 00000008
R 06 FFFFFFF8
R 07 00000005
R 08 FFFFFFFD
R 09 00000001
R 0A 00000000
R 0B 00000050
R 0C 00000005
R 0D FFFFFFFD
R 0E FFFFFFFE
R 0F FFFFFFFC
R 11 00000011
R 13 00000013
R 15 00000024
R 16 FFFFFFFF
S 00000002 FFFFFFFD
S 00000004 FFFFFFFC
S 00000000 00000024
